//--- hdl/cpu_pkg.sv
// shared definitions for the 16-bit multi-cycle core
// widths, opcodes, instruction formats and core state encoding
package cpu_pkg;

  localparam int data_w    = 16;
  localparam int reg_idx_w = 4;

  // ############################################################
  // instruction set
  // ############################################################
  typedef enum logic [2:0] {
    op_arith  = 3'b000,
    op_cmpmul = 3'b001,
    op_load   = 3'b010,
    op_store  = 3'b011,
    op_beq    = 3'b100,
    op_jump   = 3'b101
  } opcode_t;

  // funct bit meaning under op_arith / op_cmpmul
  localparam logic funct_add = 1'b0;
  localparam logic funct_sub = 1'b1;
  localparam logic funct_slt = 1'b0;
  localparam logic funct_mul = 1'b1;

  typedef struct packed {
    opcode_t              opcode;
    logic [reg_idx_w-1:0] rs;
    logic [reg_idx_w-1:0] rt;
    logic [reg_idx_w-1:0] rd;
    logic                 funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t              opcode;
    logic [reg_idx_w-1:0] rs;
    logic [reg_idx_w-1:0] rt;
    logic signed [4:0]    imm;
  } i_fmt_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [11:0] target;
    logic        unused;
  } j_fmt_t;

  // one word, three views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } instr_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_memory,
    st_writeback
  } core_state_t;

  // top bit of the bus address
  localparam logic region_instr = 1'b0;
  localparam logic region_data  = 1'b1;

endpackage

//--- hdl/load_store_unit.sv
// data access sequencer, one load or store at a time
module load_store_unit #(
  parameter int addr_w = 12
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       mem_start,
  input  logic                       we,
  input  logic [cpu_pkg::data_w-1:0] data_addr,
  input  logic [cpu_pkg::data_w-1:0] store_data,
  input  logic                       d_ack,
  input  logic [cpu_pkg::data_w-1:0] mem_rdata,
  output logic                       d_req,
  output logic                       d_we,
  output logic [addr_w:0]            d_addr,
  output logic [cpu_pkg::data_w-1:0] d_wdata,
  output logic                       mem_done,
  output logic [cpu_pkg::data_w-1:0] load_data
);
  import cpu_pkg::*;

  // request held until its ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_req <= 1'b0;
      d_we  <= 1'b0;
    end else begin
      if (d_req && d_ack) begin
        d_req <= 1'b0;
      end else if (mem_start) begin
        d_req <= 1'b1;
        d_we  <= we;
      end
    end
  end

  // done in the ack cycle
  assign mem_done = d_req && d_ack;

  always_ff @(posedge clk) begin
    if (mem_start && !d_req) begin
      d_addr  <= {region_data, data_addr[addr_w-1:0]};
      d_wdata <= store_data;
    end
    // read data held for write-back
    if (d_req && d_ack && !d_we) begin
      load_data <= mem_rdata;
    end
  end

endmodule

//--- hdl/mem_arbiter.sv
// shared bus arbiter for the fetch and data peers
// data wins when both wait; the owner holds the bus until its ack
module mem_arbiter #(
  parameter int addr_w = 12
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       f_req,
  input  logic [addr_w:0]            f_addr,
  input  logic                       d_req,
  input  logic                       d_we,
  input  logic [addr_w:0]            d_addr,
  input  logic [cpu_pkg::data_w-1:0] d_wdata,
  input  logic                       mem_ack,
  output logic                       f_ack,
  output logic                       d_ack,
  output logic                       mem_req,
  output logic                       mem_we,
  output logic [addr_w:0]            mem_addr,
  output logic [cpu_pkg::data_w-1:0] mem_wdata
);

  localparam logic [1:0] own_idle  = 2'd0;
  localparam logic [1:0] own_fetch = 2'd1;
  localparam logic [1:0] own_data  = 2'd2;

  logic [1:0] owner;

  // on an ack, hand over to the other peer if it is waiting
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner <= own_idle;
    end else begin
      case (owner)
        own_idle: begin
          if (d_req) owner <= own_data;
          else if (f_req) owner <= own_fetch;
        end
        own_fetch: if (mem_ack) owner <= d_req ? own_data : own_idle;
        own_data:  if (mem_ack) owner <= f_req ? own_fetch : own_idle;
        default:   owner <= own_idle;
      endcase
    end
  end

  assign mem_req   = (owner != own_idle);
  assign mem_we    = (owner == own_data) && d_we;
  assign mem_addr  = (owner == own_data) ? d_addr : f_addr;
  // only the data side ever writes
  assign mem_wdata = d_wdata;

  assign f_ack = mem_ack && (owner == own_fetch);
  assign d_ack = mem_ack && (owner == own_data);

endmodule

//--- hdl/fetch_unit.sv
// instruction fetch with a one-entry prefetch buffer
// a redirect flushes the buffer and drops any reply still in flight
module fetch_unit #(
  parameter int addr_w = 12
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       instr_take,
  input  logic                       redirect,
  input  logic [addr_w-1:0]          redirect_pc,
  input  logic                       f_ack,
  input  logic [cpu_pkg::data_w-1:0] mem_rdata,
  output logic                       f_req,
  output logic [addr_w:0]            f_addr,
  output logic                       instr_valid,
  output cpu_pkg::instr_t            instr,
  output logic [addr_w-1:0]          instr_pc
);
  import cpu_pkg::*;

  logic [addr_w-1:0] next_pc;
  logic [addr_w-1:0] req_pc;
  logic              discard;
  logic              issue;
  logic              reply;
  logic              fill;

  // request when the buffer is empty or is being emptied now
  assign issue = !f_req && (!instr_valid || instr_take) && !redirect;
  assign reply = f_req && f_ack;
  assign fill  = reply && !discard && !redirect;

  assign f_addr = {region_instr, req_pc};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      f_req       <= 1'b0;
      next_pc     <= '0;
      discard     <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      if (reply) begin
        f_req <= 1'b0;
      end else if (issue) begin
        f_req <= 1'b1;
      end

      if (redirect) begin
        next_pc <= redirect_pc;
      end else if (issue) begin
        next_pc <= next_pc + addr_w'(1);
      end

      // stale reply after a flush
      if (reply) begin
        discard <= 1'b0;
      end else if (redirect && f_req) begin
        discard <= 1'b1;
      end

      if (redirect) begin
        instr_valid <= 1'b0;
      end else if (fill) begin
        instr_valid <= 1'b1;
      end else if (instr_take) begin
        instr_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_pc <= next_pc;
    end
    if (fill) begin
      instr    <= mem_rdata;
      instr_pc <= req_pc;
    end
  end

endmodule

//--- hdl/exec_unit.sv
// datapath: sixteen signed registers, operand latches, ALU and write-back
module exec_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  cpu_pkg::core_state_t       state,
  input  cpu_pkg::instr_t            cur_instr,
  input  logic [cpu_pkg::data_w-1:0] load_data,
  output logic                       rs_eq_rt,
  output logic [cpu_pkg::data_w-1:0] data_addr,
  output logic [cpu_pkg::data_w-1:0] store_data
);
  import cpu_pkg::*;

  localparam int num_regs = 2 ** reg_idx_w;

  logic signed [data_w-1:0] regs [num_regs];
  logic signed [data_w-1:0] op_a;
  logic signed [data_w-1:0] op_b;
  logic signed [data_w-1:0] alu_out;
  logic signed [data_w-1:0] alu_res;
  logic signed [data_w-1:0] imm_ext;
  opcode_t                  op;
  logic                     use_imm;

  assign op      = cur_instr.r_fmt.opcode;
  assign use_imm = (op == op_load) || (op == op_store);
  assign imm_ext = data_w'($signed(cur_instr.i_fmt.imm));

  // operand capture in decode
  always_ff @(posedge clk) begin
    if (state == st_decode) begin
      op_a <= regs[cur_instr.i_fmt.rs];
      op_b <= use_imm ? imm_ext : regs[cur_instr.i_fmt.rt];
    end
  end

  // ############################################################
  // ALU
  // ############################################################
  always_comb begin
    case (op)
      op_arith:  alu_out = (cur_instr.r_fmt.funct == funct_sub) ? op_a - op_b : op_a + op_b;
      op_cmpmul: begin
        if (cur_instr.r_fmt.funct == funct_mul) begin
          // low half of the signed product
          alu_out = op_a * op_b;
        end else begin
          alu_out = {{(data_w-1){1'b0}}, (op_a < op_b)};
        end
      end
      default:   alu_out = op_a + op_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == st_execute) begin
      alu_res <= alu_out;
    end
  end

  assign rs_eq_rt   = (op_a == op_b);
  assign data_addr  = op_a + op_b;
  assign store_data = regs[cur_instr.i_fmt.rt];

  // write-back to rd for ALU ops, to rt for loads
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (state == st_writeback) begin
      if (op == op_arith || op == op_cmpmul) begin
        regs[cur_instr.r_fmt.rd] <= alu_res;
      end else if (op == op_load) begin
        regs[cur_instr.i_fmt.rt] <= load_data;
      end
    end
  end

endmodule

//--- hdl/core_ctrl.sv
// core control: state machine, program counter and instruction register
// resolves branch and jump targets and signals retirement on io_stall
module core_ctrl #(
  parameter int addr_w = 12
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  cpu_pkg::instr_t      instr,
  input  logic [addr_w-1:0]    instr_pc,
  input  logic                 mem_done,
  input  logic                 rs_eq_rt,
  output logic                 instr_take,
  output logic                 redirect,
  output logic [addr_w-1:0]    redirect_pc,
  output logic                 mem_start,
  output cpu_pkg::core_state_t state,
  output cpu_pkg::instr_t      cur_instr,
  output logic                 io_stall
);
  import cpu_pkg::*;

  core_state_t       next_state;
  opcode_t           op;
  logic [addr_w-1:0] pc;
  logic [addr_w-1:0] branch_pc;
  logic [addr_w-1:0] jump_pc;
  logic              is_mem;
  logic              is_redirect_op;

  assign op             = cur_instr.r_fmt.opcode;
  assign is_mem         = (op == op_load) || (op == op_store);
  assign is_redirect_op = (op == op_beq) || (op == op_jump);

  // ############################################################
  // state machine
  // ############################################################
  always_comb begin
    next_state = state;
    case (state)
      st_fetch:     if (instr_valid) next_state = st_decode;
      st_decode:    next_state = st_execute;
      st_execute:   next_state = is_mem ? st_memory : st_writeback;
      st_memory:    if (mem_done) next_state = st_writeback;
      st_writeback: next_state = st_fetch;
      default:      next_state = st_fetch;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_fetch;
    end else begin
      state <= next_state;
    end
  end

  // accept the buffered instruction together with its address
  assign instr_take = (state == st_fetch) && instr_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_instr <= '0;
      pc        <= '0;
    end else if (instr_take) begin
      cur_instr <= instr;
      pc        <= instr_pc;
    end
  end

  // ############################################################
  // redirection and memory start
  // ############################################################
  // branch target relative to the next instruction
  assign branch_pc = pc + addr_w'(1) + addr_w'($signed(cur_instr.i_fmt.imm));
  // jump target wraps into the instruction region
  assign jump_pc   = addr_w'(cur_instr.j_fmt.target);

  assign redirect_pc = (op == op_jump) ? jump_pc : branch_pc;

  always_comb begin
    redirect = 1'b0;
    if (state == st_execute && is_redirect_op) begin
      redirect = (op == op_jump) || rs_eq_rt;
    end
  end

  assign mem_start = (state == st_execute) && is_mem;

  // low for one cycle once writeback is done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      io_stall <= 1'b1;
    end else begin
      io_stall <= (state != st_writeback);
    end
  end

endmodule

//--- hdl/cpu_top.sv
// processor top level
// core control and datapath, fetch and load/store peers, shared bus arbiter
module cpu_top #(
  parameter int addr_w = 12
) (
  input  logic                       clk,
  input  logic                       rst_n,
  output logic                       io_stall,
  output logic                       mem_req,
  output logic                       mem_we,
  output logic [addr_w:0]            mem_addr,
  output logic [cpu_pkg::data_w-1:0] mem_wdata,
  input  logic                       mem_ack,
  input  logic [cpu_pkg::data_w-1:0] mem_rdata
);
  import cpu_pkg::*;

  // fetch to core
  logic              instr_valid;
  instr_t            instr;
  logic [addr_w-1:0] instr_pc;
  logic              instr_take;
  logic              redirect;
  logic [addr_w-1:0] redirect_pc;

  // core internals
  core_state_t       state;
  instr_t            cur_instr;
  logic              rs_eq_rt;
  logic [data_w-1:0] data_addr;
  logic [data_w-1:0] store_data;

  // load/store handshake
  logic              mem_start;
  logic              mem_done;
  logic [data_w-1:0] load_data;

  // peer requests into the arbiter
  logic              f_req;
  logic [addr_w:0]   f_addr;
  logic              f_ack;
  logic              d_req;
  logic              d_we;
  logic [addr_w:0]   d_addr;
  logic [data_w-1:0] d_wdata;
  logic              d_ack;

  core_ctrl #(.addr_w(addr_w)) u_core_ctrl (
    .clk, .rst_n, .instr_valid, .instr, .instr_pc, .mem_done, .rs_eq_rt,
    .instr_take, .redirect, .redirect_pc, .mem_start, .state, .cur_instr, .io_stall
  );

  exec_unit u_exec_unit (
    .clk, .rst_n, .state, .cur_instr, .load_data,
    .rs_eq_rt, .data_addr, .store_data
  );

  fetch_unit #(.addr_w(addr_w)) u_fetch_unit (
    .clk, .rst_n, .instr_take, .redirect, .redirect_pc, .f_ack, .mem_rdata,
    .f_req, .f_addr, .instr_valid, .instr, .instr_pc
  );

  load_store_unit #(.addr_w(addr_w)) u_load_store_unit (
    .clk, .rst_n, .mem_start,
    .we(cur_instr.i_fmt.opcode == op_store),
    .data_addr, .store_data, .d_ack, .mem_rdata,
    .d_req, .d_we, .d_addr, .d_wdata, .mem_done, .load_data
  );

  mem_arbiter #(.addr_w(addr_w)) u_mem_arbiter (
    .clk, .rst_n, .f_req, .f_addr, .d_req, .d_we, .d_addr, .d_wdata, .mem_ack,
    .f_ack, .d_ack, .mem_req, .mem_we, .mem_addr, .mem_wdata
  );

endmodule

//--- verif/cpu_model.svh
// instruction-set reference model for the 16-bit core
// memory images, random program generator and a one-instruction step
`ifndef cpu_model_svh
`define cpu_model_svh

localparam int mem_words = 2 ** addr_w;

logic [data_w-1:0]        imem       [mem_words];
logic [data_w-1:0]        bus_dmem   [mem_words];
logic [data_w-1:0]        model_dmem [mem_words];
logic signed [data_w-1:0] m_regs     [16];
logic [addr_w-1:0]        m_pc;
logic [addr_w-1:0]        m_st_addr  [$];
logic [data_w-1:0]        m_st_data  [$];

// kind 0 alu and store, 1 load/store pairs, 2 branch and jump, 3 full mix
function automatic logic [data_w-1:0] random_instr(input int kind, input int a);
  instr_t ins;
  instr_t prev;
  int     pick;
  ins  = 16'($urandom);
  pick = int'($urandom_range(99, 0));
  case (kind)
    0: ins.r_fmt.opcode = (pick < 35) ? op_arith : (pick < 65) ? op_cmpmul :
                          (pick < 85) ? op_store : op_load;
    1: begin
      if (a % 2 == 0) begin
        ins.i_fmt.opcode = op_load;
      end else begin
        // store back the register loaded just before
        prev             = imem[a-1];
        ins.i_fmt.opcode = op_store;
        ins.i_fmt.rt     = prev.i_fmt.rt;
      end
    end
    2: ins.r_fmt.opcode = (pick < 20) ? op_beq : (pick < 32) ? op_jump :
                          (pick < 60) ? op_arith : (pick < 75) ? op_cmpmul :
                          (pick < 88) ? op_store : op_load;
    // kind 3 keeps the random opcode including the spare codes
    default: ;
  endcase
  // no single-word branch loop
  if (ins.i_fmt.opcode == op_beq && ins.i_fmt.imm == -5'sd1) begin
    ins.i_fmt.imm = 5'sd2;
  end
  return ins;
endfunction

task automatic load_program(input int kind);
  for (int a = 0; a < mem_words; a++) begin
    imem[a]       = random_instr(kind, a);
    bus_dmem[a]   = 16'($urandom);
    model_dmem[a] = bus_dmem[a];
  end
endtask

task automatic model_reset();
  for (int r = 0; r < 16; r++) begin
    m_regs[r] = '0;
  end
  m_pc = '0;
  m_st_addr.delete();
  m_st_data.delete();
endtask

// steps one instruction at m_pc and flags a taken beq or a jump
task automatic model_step(output logic redirected);
  instr_t                   ins;
  logic signed [data_w-1:0] a_val;
  logic signed [data_w-1:0] b_val;
  logic signed [data_w-1:0] imm_ext;
  logic signed [31:0]       prod;
  logic [addr_w-1:0]        eff;
  logic [addr_w-1:0]        next_pc;
  ins        = imem[m_pc];
  a_val      = m_regs[ins.i_fmt.rs];
  b_val      = m_regs[ins.i_fmt.rt];
  imm_ext    = {{11{ins.i_fmt.imm[4]}}, ins.i_fmt.imm};
  eff        = addr_w'(a_val + imm_ext);
  next_pc    = m_pc + addr_w'(1);
  redirected = 1'b0;
  case (ins.r_fmt.opcode)
    op_arith: begin
      m_regs[ins.r_fmt.rd] = ins.r_fmt.funct ? a_val - b_val : a_val + b_val;
    end
    op_cmpmul: begin
      prod = 32'(a_val) * 32'(b_val);
      if (ins.r_fmt.funct) begin
        m_regs[ins.r_fmt.rd] = prod[15:0];
      end else begin
        m_regs[ins.r_fmt.rd] = (a_val < b_val) ? 16'sd1 : 16'sd0;
      end
    end
    op_load:  m_regs[ins.i_fmt.rt] = model_dmem[eff];
    op_store: begin
      model_dmem[eff] = b_val;
      m_st_addr.push_back(eff);
      m_st_data.push_back(b_val);
    end
    op_beq: begin
      if (a_val == b_val) begin
        next_pc    = m_pc + addr_w'(1) + addr_w'(imm_ext);
        redirected = 1'b1;
      end
    end
    op_jump: begin
      next_pc    = addr_w'(ins.j_fmt.target);
      redirected = 1'b1;
    end
    default: ;
  endcase
  m_pc = next_pc;
endtask

`endif

//--- verif/cpu_tb.sv
// testbench for the 16-bit multi-cycle core
// random programs with random bus latency, checked against the ISA model
module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  localparam int addr_w       = 12;
  localparam int max_lat      = 4;
  localparam int n_alu        = 300;
  localparam int n_load       = 200;
  localparam int n_branch     = 300;
  localparam int n_mixed      = 1000;
  localparam int limit_cycles = (n_alu + n_load + n_branch + n_mixed) * 4 * max_lat + 2000;

  logic              clk;
  logic              rst_n;
  logic              io_stall;
  logic              mem_req;
  logic              mem_we;
  logic [addr_w:0]   mem_addr;
  logic [data_w-1:0] mem_wdata;
  logic              mem_ack;
  logic [data_w-1:0] mem_rdata;

  `include "cpu_model.svh"

  // memory responder state
  logic              busy;
  int                lat_left;
  logic [addr_w:0]   held_addr;
  logic              held_we;
  logic [data_w-1:0] held_wdata;
  logic [addr_w-1:0] fetch_q     [$];
  logic [addr_w-1:0] obs_st_addr [$];
  logic [data_w-1:0] obs_st_data [$];

  logic              prev_redirect;
  logic [addr_w-1:0] prev_pc;
  int                retired;
  int                stores_seen;
  int                test_errors;
  int                total_errors;
  int                tests_failed;
  int                tests_run;

  cpu_top #(.addr_w(addr_w)) u_cpu_top (
    .clk, .rst_n, .io_stall, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
  );

  always begin
    #50 clk = ~clk;
  end

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the core stopped retiring", limit_cycles);
    $display("Checks failed");
    $finish;
  end

  task automatic flag_mismatch(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    test_errors++;
  endtask

  task automatic flag_fault(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    test_errors++;
  endtask

  // ##########################################################
  // memory responder
  // ##########################################################
  task automatic complete_access();
    logic [addr_w-1:0] a;
    a = held_addr[addr_w-1:0];
    if (held_addr[addr_w] == region_data && held_we) begin
      bus_dmem[a] = held_wdata;
      obs_st_addr.push_back(a);
      obs_st_data.push_back(held_wdata);
    end else if (held_addr[addr_w] == region_data) begin
      mem_rdata = bus_dmem[a];
    end else begin
      if (held_we) begin
        flag_fault($sformatf("write into the instruction region at %h", a));
      end
      mem_rdata = imem[a];
      fetch_q.push_back(a);
    end
  endtask

  task automatic service_bus();
    if (!rst_n) begin
      mem_ack = 1'b0;
      busy    = 1'b0;
    end else begin
      if (mem_ack) begin
        mem_ack = 1'b0;
        busy    = 1'b0;
      end
      if (mem_req && !busy) begin
        busy       = 1'b1;
        lat_left   = $urandom_range(max_lat, 1) - 1;
        held_addr  = mem_addr;
        held_we    = mem_we;
        held_wdata = mem_wdata;
      end else if (mem_req) begin
        if (mem_addr !== held_addr || mem_we !== held_we ||
            (held_we && mem_wdata !== held_wdata)) begin
          flag_mismatch($sformatf("request changed before ack, addr %h we %b data %h",
                                  mem_addr, mem_we, mem_wdata));
        end
      end else if (busy) begin
        flag_fault("bus request withdrawn before its ack");
        busy = 1'b0;
      end
      if (busy && lat_left > 0) begin
        lat_left--;
      end else if (busy) begin
        complete_access();
        mem_ack = 1'b1;
      end
    end
  endtask

  // ##########################################################
  // retirement against the model
  // ##########################################################
  task automatic check_retirement();
    logic              redir;
    logic [addr_w-1:0] pc_now;
    logic [addr_w-1:0] got;
    logic [addr_w-1:0] exp_a;
    logic [data_w-1:0] exp_d;
    pc_now = m_pc;
    // fall-through prefetch flushed by the last redirect
    if (prev_redirect && fetch_q.size() == 0) begin
      flag_fault("no fetch seen for the word after a redirect");
    end else if (prev_redirect) begin
      got = fetch_q.pop_front();
      if (got != prev_pc + addr_w'(1)) begin
        flag_mismatch($sformatf("flushed fetch %h, expected %h", got, prev_pc + addr_w'(1)));
      end
    end
    if (fetch_q.size() == 0) begin
      flag_fault("instruction retired without a fetch");
    end else begin
      got = fetch_q.pop_front();
      if (got != pc_now) begin
        flag_mismatch($sformatf("retired fetch %h, model pc %h", got, pc_now));
      end
    end
    model_step(redir);
    prev_redirect = redir;
    prev_pc       = pc_now;
    retired++;
    if (m_st_addr.size() > 0) begin
      exp_a = m_st_addr.pop_front();
      exp_d = m_st_data.pop_front();
      if (obs_st_addr.size() == 0) begin
        flag_fault($sformatf("store to %h retired with no bus write", exp_a));
      end else if (obs_st_addr[0] != exp_a || obs_st_data[0] != exp_d) begin
        flag_mismatch($sformatf("store %h <= %h, model %h <= %h",
                                obs_st_addr[0], obs_st_data[0], exp_a, exp_d));
      end else begin
        stores_seen++;
      end
      if (obs_st_addr.size() > 0) begin
        void'(obs_st_addr.pop_front());
        void'(obs_st_data.pop_front());
      end
    end
    if (obs_st_addr.size() > 0) begin
      flag_fault("bus write seen with no store retiring");
      obs_st_addr.delete();
      obs_st_data.delete();
    end
  endtask

  task automatic tick();
    @(negedge clk);
    service_bus();
    if (rst_n && !io_stall) begin
      check_retirement();
    end
  endtask

  task automatic check_idle();
    if (io_stall !== 1'b1 || mem_req !== 1'b0) begin
      flag_mismatch($sformatf("io_stall %b mem_req %b around reset", io_stall, mem_req));
    end
  endtask

  task automatic apply_reset();
    fetch_q.delete();
    obs_st_addr.delete();
    obs_st_data.delete();
    model_reset();
    prev_redirect = 1'b0;
    prev_pc       = '0;
    rst_n         = 1'b0;
    repeat (8) begin
      tick();
      check_idle();
    end
    rst_n = 1'b1;
    tick();
    check_idle();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors > 0) begin
      tests_failed++;
    end
    $display("test %s: %0d retired, %0d stores matched, %0d errors",
             name, retired, stores_seen, test_errors);
  endtask

  task automatic run_test(input string name, input int kind, input int count);
    test_errors = 0;
    stores_seen = 0;
    retired     = 0;
    load_program(kind);
    apply_reset();
    while (retired < count) begin
      tick();
    end
    finish_test(name);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    mem_ack      = 1'b0;
    mem_rdata    = '0;
    busy         = 1'b0;
    lat_left     = 0;
    total_errors = 0;
    tests_failed = 0;
    tests_run    = 0;
    test_errors  = 0;
    stores_seen  = 0;
    retired      = 0;
    void'($urandom(14304));
    apply_reset();
    finish_test("reset");
    run_test("alu_store", 0, n_alu);
    run_test("load", 1, n_load);
    run_test("branch_jump", 2, n_branch);
    run_test("mixed_contention", 3, n_mixed);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- cpu_top.f
+incdir+verif
hdl/cpu_pkg.sv
hdl/load_store_unit.sv
hdl/mem_arbiter.sv
hdl/fetch_unit.sv
hdl/exec_unit.sv
hdl/core_ctrl.sv
hdl/cpu_top.sv
verif/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the core testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cpu_tb -f cpu_top.f

out="$(./obj_dir/Vcpu_tb)"
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
